//--- src/rv32_pkg.sv
// ====================
// Widths, RV32I encodings and the instruction class shared by the hart units
// Pulled into each module header with a wildcard import
// ====================
`default_nettype none

package rv32_pkg;
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int STRB_W     = 4;

	localparam logic [6:0] OPC_LUI    = 7'b01_101_11;
	localparam logic [6:0] OPC_AUIPC  = 7'b00_101_11;
	localparam logic [6:0] OPC_JAL    = 7'b11_011_11;
	localparam logic [6:0] OPC_JALR   = 7'b11_001_11;
	localparam logic [6:0] OPC_BRANCH = 7'b11_000_11;
	localparam logic [6:0] OPC_LOAD   = 7'b00_000_11;
	localparam logic [6:0] OPC_STORE  = 7'b01_000_11;
	localparam logic [6:0] OPC_OP     = 7'b01_100_11;
	localparam logic [6:0] OPC_OP_IMM = 7'b00_100_11;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	localparam logic [2:0] F3_ADD  = 3'b000; // Also SUB
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_LUI,
		CLS_AUIPC,
		CLS_JAL,
		CLS_JALR,
		CLS_BRANCH,
		CLS_LOAD,
		CLS_STORE
	} op_class_t;

	localparam logic [STRB_W-1:0] MASK_BYTE = 4'b0001;
	localparam logic [STRB_W-1:0] MASK_HALF = 4'b0011;
	localparam logic [STRB_W-1:0] MASK_WORD = 4'b1111;
endpackage

`default_nettype wire

//--- src/insn_decoder.sv
// ====================
// RV32I field split, immediate select and illegal encoding check
// ====================
`timescale 1ns/10ps
`default_nettype none

module insn_decoder import rv32_pkg::*; (
	input  wire  [XLEN-1:0]       insn,
	output op_class_t             op_class,
	output logic [2:0]            funct3,
	output logic                  alt,
	output logic [REG_ADDR_W-1:0] rs1_addr,
	output logic [REG_ADDR_W-1:0] rs2_addr,
	output logic [REG_ADDR_W-1:0] rd_addr,
	output logic                  uses_rs2_reg,
	output logic                  writes_rd,
	output logic                  is_mem,
	output logic                  illegal,
	output logic [XLEN-1:0]       imm
);
	logic [6:0]      opcode;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	assign opcode   = insn[6:0];
	assign funct3   = insn[14:12];
	assign funct7   = insn[31:25];
	assign alt      = insn[30]; // SUB or SRA select
	assign rd_addr  = insn[11:7];
	assign rs1_addr = insn[19:15];
	assign rs2_addr = insn[24:20];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	always_comb begin
		op_class     = CLS_ALU;
		imm          = imm_i;
		uses_rs2_reg = 1'b0;
		writes_rd    = 1'b0;
		is_mem       = 1'b0;
		illegal      = 1'b0;
		case (opcode)
			OPC_LUI: begin
				op_class  = CLS_LUI;
				imm       = imm_u;
				writes_rd = 1'b1;
			end
			OPC_AUIPC: begin
				op_class  = CLS_AUIPC;
				imm       = imm_u;
				writes_rd = 1'b1;
			end
			OPC_JAL: begin
				op_class  = CLS_JAL;
				imm       = imm_j;
				writes_rd = 1'b1;
			end
			OPC_JALR: begin
				op_class  = CLS_JALR;
				writes_rd = 1'b1;
				illegal   = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				op_class     = CLS_BRANCH;
				imm          = imm_b;
				uses_rs2_reg = 1'b1;
				illegal      = !(funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
			end
			OPC_LOAD: begin
				op_class  = CLS_LOAD;
				writes_rd = 1'b1;
				is_mem    = 1'b1;
				illegal   = !(funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
			end
			OPC_STORE: begin
				op_class     = CLS_STORE;
				imm          = imm_s;
				uses_rs2_reg = 1'b1;
				is_mem       = 1'b1;
				illegal      = !(funct3 inside {F3_SB, F3_SH, F3_SW});
			end
			OPC_OP: begin
				uses_rs2_reg = 1'b1;
				writes_rd    = 1'b1;
				illegal      = !((funct7 == F7_BASE)
					|| (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)));
			end
			OPC_OP_IMM: begin
				writes_rd = 1'b1; // Immediate stands in for rs2
				if (funct3 == F3_SLL) begin
					illegal = (funct7 != F7_BASE);
				end else if (funct3 == F3_SR) begin
					illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
				end
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- src/alu.sv
// ====================
// Integer ALU for OP and OP-IMM, plus the compare flags used by branches
// ====================
`timescale 1ns/10ps
`default_nettype none

module alu import rv32_pkg::*; (
	input  wire  [XLEN-1:0] a,
	input  wire  [XLEN-1:0] b,
	input  wire  [2:0]      funct3,
	input  wire             alt,
	input  wire             is_imm,
	output logic [XLEN-1:0] result,
	output logic            eq,
	output logic            lt,
	output logic            ltu
);
	localparam int SHAMT_W = $clog2(XLEN);

	logic [SHAMT_W-1:0] shamt;
	logic               do_sub;

	assign shamt  = b[SHAMT_W-1:0];
	assign do_sub = alt && !is_imm; // ADDI has no subtract form

	assign eq  = (a == b);
	assign lt  = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb begin
		case (funct3)
			F3_ADD:  result = do_sub ? a - b : a + b;
			F3_SLL:  result = a << shamt;
			F3_SLT:  result = {{(XLEN-1){1'b0}}, lt};
			F3_SLTU: result = {{(XLEN-1){1'b0}}, ltu};
			F3_XOR:  result = a ^ b;
			F3_SR: begin
				if (alt) begin
					result = $signed(a) >>> shamt; // Arithmetic keeps the sign
				end else begin
					result = a >> shamt;
				end
			end
			F3_OR:   result = a | b;
			F3_AND:  result = a & b;
			default: result = a + b;
		endcase
	end

endmodule

`default_nettype wire

//--- src/next_pc.sv
// ====================
// Next fetch address for sequential flow, branches, JAL and JALR
// ====================
`timescale 1ns/10ps
`default_nettype none

module next_pc import rv32_pkg::*; (
	input  wire  [XLEN-1:0] pc,
	input  wire  [XLEN-1:0] rs1_data,
	input  wire  [XLEN-1:0] imm,
	input  var op_class_t   op_class,
	input  wire  [2:0]      funct3,
	input  wire             eq,
	input  wire             lt,
	input  wire             ltu,
	output logic [XLEN-1:0] pc_next,
	output logic [XLEN-1:0] pc_plus4
);
	logic            taken;
	logic [XLEN-1:0] jalr_target;

	assign pc_plus4    = pc + XLEN'(4); // Also the link value
	assign jalr_target = rs1_data + imm;

	always_comb begin
		case (funct3)
			F3_BEQ:  taken = eq;
			F3_BNE:  taken = !eq;
			F3_BLT:  taken = lt;
			F3_BGE:  taken = !lt;
			F3_BLTU: taken = ltu;
			F3_BGEU: taken = !ltu;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (op_class)
			CLS_JAL:    pc_next = pc + imm;
			CLS_JALR:   pc_next = {jalr_target[XLEN-1:1], 1'b0};
			CLS_BRANCH: pc_next = taken ? pc + imm : pc_plus4;
			default:    pc_next = pc_plus4;
		endcase
	end

endmodule

`default_nettype wire

//--- src/load_store_unit.sv
// ====================
// Address, strobes and write data for the data port, and load extension
// Data sits in the low lanes, no byte shifting by address
// ====================
`timescale 1ns/10ps
`default_nettype none

module load_store_unit import rv32_pkg::*; (
	input  var op_class_t     op_class,
	input  wire  [2:0]        funct3,
	input  wire  [XLEN-1:0]   rs1_data,
	input  wire  [XLEN-1:0]   rs2_data,
	input  wire  [XLEN-1:0]   imm,
	input  wire  [XLEN-1:0]   mem_rdata,
	output logic [XLEN-1:0]   mem_addr,
	output logic [XLEN-1:0]   mem_wdata,
	output logic [STRB_W-1:0] mem_wstrb,
	output logic [STRB_W-1:0] mem_rmask,
	output logic [XLEN-1:0]   load_data
);
	logic is_load;
	logic is_store;

	assign is_load  = (op_class == CLS_LOAD);
	assign is_store = (op_class == CLS_STORE);

	assign mem_addr  = (is_load || is_store) ? rs1_data + imm : '0;
	assign mem_wdata = is_store ? rs2_data : '0;

	always_comb begin
		mem_wstrb = '0;
		if (is_store) begin
			case (funct3)
				F3_SB:   mem_wstrb = MASK_BYTE;
				F3_SH:   mem_wstrb = MASK_HALF;
				F3_SW:   mem_wstrb = MASK_WORD;
				default: mem_wstrb = '0; // Reserved width, decoder traps it
			endcase
		end
	end

	always_comb begin
		mem_rmask = '0;
		load_data = mem_rdata;
		if (is_load) begin
			case (funct3)
				F3_LB: begin
					mem_rmask = MASK_BYTE;
					load_data = {{(XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
				end
				F3_LBU: begin
					mem_rmask = MASK_BYTE;
					load_data = {{(XLEN-8){1'b0}}, mem_rdata[7:0]};
				end
				F3_LH: begin
					mem_rmask = MASK_HALF;
					load_data = {{(XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
				end
				F3_LHU: begin
					mem_rmask = MASK_HALF;
					load_data = {{(XLEN-16){1'b0}}, mem_rdata[15:0]};
				end
				F3_LW:   mem_rmask = MASK_WORD;
				default: mem_rmask = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/register_file.sv
// ====================
// General registers x1..x31, two async reads, one write at the clock edge
// ====================
`timescale 1ns/10ps
`default_nettype none

module register_file import rv32_pkg::*; (
	input  wire                   clk,
	input  wire                   reset,
	input  wire  [REG_ADDR_W-1:0] rs1_addr,
	input  wire  [REG_ADDR_W-1:0] rs2_addr,
	input  wire  [REG_ADDR_W-1:0] rd_addr,
	input  wire                   rd_we,
	input  wire  [XLEN-1:0]       rd_data,
	output logic [XLEN-1:0]       rs1_data,
	output logic [XLEN-1:0]       rs2_data
);
	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	logic [XLEN-1:0] regs [1:NUM_REGS-1]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd_addr != '0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- src/rv32_hart.sv
// ====================
// Single-cycle RV32I hart, one instruction per cycle unless the data port stalls
// ====================
`timescale 1ns/10ps
`default_nettype none

module rv32_hart import rv32_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  wire                clk,
	input  wire                reset,
	output logic [XLEN-1:0]    insn_addr,
	input  wire  [XLEN-1:0]    insn,
	input  wire                insn_valid,
	output logic               mem_valid,
	output logic [XLEN-1:0]    mem_addr,
	output logic [XLEN-1:0]    mem_wdata,
	output logic [STRB_W-1:0]  mem_wstrb,
	output logic [STRB_W-1:0]  mem_rmask,
	input  wire  [XLEN-1:0]    mem_rdata,
	input  wire                mem_ready,
	output logic               trap
);
	logic [XLEN-1:0]       pc;
	op_class_t             op_class;
	logic [2:0]            funct3;
	logic                  alt;
	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic                  uses_rs2_reg;
	logic                  writes_rd;
	logic                  is_mem;
	logic                  illegal;
	logic [XLEN-1:0]       imm;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	logic [XLEN-1:0]       alu_b;
	logic [XLEN-1:0]       alu_result;
	logic                  eq;
	logic                  lt;
	logic                  ltu;
	logic [XLEN-1:0]       pc_next;
	logic [XLEN-1:0]       pc_plus4;
	logic [STRB_W-1:0]     lsu_wstrb;
	logic [STRB_W-1:0]     lsu_rmask;
	logic [XLEN-1:0]       load_data;
	logic [XLEN-1:0]       rd_data;
	logic                  complete;

	insn_decoder decoder_i (
		.insn(insn), .op_class(op_class), .funct3(funct3), .alt(alt),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
		.uses_rs2_reg(uses_rs2_reg), .writes_rd(writes_rd), .is_mem(is_mem),
		.illegal(illegal), .imm(imm)
	);

	register_file register_file_i (
		.clk(clk), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rd_addr(rd_addr), .rd_we(complete && writes_rd), .rd_data(rd_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	assign alu_b = uses_rs2_reg ? rs2_data : imm; // OP-IMM takes the immediate

	alu alu_i (
		.a(rs1_data), .b(alu_b), .funct3(funct3), .alt(alt), .is_imm(!uses_rs2_reg),
		.result(alu_result), .eq(eq), .lt(lt), .ltu(ltu)
	);

	next_pc next_pc_i (
		.pc(pc), .rs1_data(rs1_data), .imm(imm), .op_class(op_class), .funct3(funct3),
		.eq(eq), .lt(lt), .ltu(ltu), .pc_next(pc_next), .pc_plus4(pc_plus4)
	);

	load_store_unit load_store_unit_i (
		.op_class(op_class), .funct3(funct3), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.imm(imm), .mem_rdata(mem_rdata), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wstrb(lsu_wstrb), .mem_rmask(lsu_rmask), .load_data(load_data)
	);

	assign insn_addr = pc;
	assign trap      = insn_valid && illegal;
	assign mem_valid = insn_valid && is_mem && !illegal;
	assign mem_wstrb = mem_valid ? lsu_wstrb : '0;
	assign mem_rmask = mem_valid ? lsu_rmask : '0;
	assign complete  = insn_valid && !illegal && (!mem_valid || mem_ready);

	always_comb begin
		case (op_class)
			CLS_LUI:           rd_data = imm;
			CLS_AUIPC:         rd_data = pc + imm;
			CLS_JAL, CLS_JALR: rd_data = pc_plus4; // Link
			CLS_LOAD:          rd_data = load_data;
			default:           rd_data = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (complete) begin
			pc <= pc_next; // Holds on stall and for good after a trap
		end
	end

	assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
		else $error("PC lost halfword alignment");

endmodule

`default_nettype wire

//--- bench/rv32_hart_tb.sv
// ====================
// Testbench for the RV32I hart, serves a table of instructions and memory data
// Checks fetch addresses, store data and strobes, load masks and the trap
// ====================
`timescale 1ns/10ps
`default_nettype none

module rv32_hart_tb;
	localparam logic [31:0] RESET_PC = 32'h0000_1000;
	localparam logic [6:0]  LUI      = 7'b0110111;
	localparam logic [6:0]  AUIPC    = 7'b0010111;
	localparam logic [6:0]  JAL      = 7'b1101111;
	localparam logic [6:0]  JALR     = 7'b1100111;
	localparam logic [6:0]  BRANCH   = 7'b1100011;
	localparam logic [6:0]  LOAD     = 7'b0000011;
	localparam logic [6:0]  STORE    = 7'b0100011;
	localparam logic [6:0]  OP       = 7'b0110011;
	localparam logic [6:0]  OP_IMM   = 7'b0010011;
	localparam int          K_NONE   = 0;
	localparam int          K_LOAD   = 1;
	localparam int          K_STORE  = 2;

	logic        clk = 1'b0;
	logic        reset;
	logic [31:0] insn_addr;
	logic [31:0] insn;
	logic        insn_valid;
	logic        mem_valid;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic [3:0]  mem_rmask;
	logic [31:0] mem_rdata;
	logic        mem_ready;
	logic        trap;

	// Program table, one entry per served instruction
	logic [31:0] tbl_insn[$];
	logic [31:0] tbl_pc[$];
	logic [31:0] tbl_addr[$];
	logic [31:0] tbl_rdata[$];
	logic [31:0] tbl_wdata[$];
	logic [3:0]  tbl_mask[$];
	int          tbl_kind[$];
	logic [31:0] cur_pc;
	logic [31:0] end_pc; // Fetch address after the last entry
	integer      seed;
	int          errors;

	always #4 clk = ~clk;

	rv32_hart #(.RESET_PC(RESET_PC)) rv32_hart_i (
		.clk(clk), .reset(reset), .insn_addr(insn_addr), .insn(insn), .insn_valid(insn_valid),
		.mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .mem_rmask(mem_rmask), .mem_rdata(mem_rdata),
		.mem_ready(mem_ready), .trap(trap)
	);

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
			input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic add_step(input logic [31:0] word, input logic [31:0] addr,
			input logic [31:0] rdata, input logic [31:0] wdata,
			input logic [3:0] mask, input int kind);
		tbl_insn.push_back(word);
		tbl_pc.push_back(cur_pc);
		tbl_addr.push_back(addr);
		tbl_rdata.push_back(rdata);
		tbl_wdata.push_back(wdata);
		tbl_mask.push_back(mask);
		tbl_kind.push_back(kind);
		cur_pc = cur_pc + 32'd4; // Sequential fetch unless the caller redirects
	endtask

	task automatic plain(input logic [31:0] word);
		add_step(word, 32'h0, 32'h0, 32'h0, 4'h0, K_NONE);
	endtask

	task automatic store_word(input logic [4:0] rs2, input logic [31:0] exp);
		add_step(enc_s(3'b010, rs2, 5'd0, 12'h100), 32'h100, 32'h0, exp, 4'b1111, K_STORE);
	endtask

	task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [31:0] rdata,
			input logic [3:0] mask);
		add_step(enc_i(LOAD, f3, rd, 5'd0, 12'h004), 32'h4, rdata, 32'h0, mask, K_LOAD);
	endtask

	task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
			input logic taken);
		logic [31:0] base;
		base = cur_pc;
		plain(enc_b(f3, rs1, rs2, 13'd8));
		if (taken) begin
			cur_pc = base + 32'd8;
		end
	endtask

	task automatic build_program();
		logic [31:0] base;
		logic [31:0] x21_val;
		cur_pc = RESET_PC;
		plain(enc_u(LUI, 5'd1, 20'h12345));
		plain(enc_i(OP_IMM, 3'b000, 5'd1, 5'd1, 12'h678));
		store_word(5'd1, 32'h1234_5678);
		plain(enc_i(OP_IMM, 3'b000, 5'd2, 5'd0, 12'hffb)); // x2 = -5
		plain(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		store_word(5'd3, 32'h1234_5673);
		plain(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4)); // SUB
		store_word(5'd4, 32'h1234_567d);
		plain(enc_i(OP_IMM, 3'b000, 5'd5, 5'd0, 12'h004));
		plain(enc_r(7'h00, 5'd5, 5'd1, 3'b001, 5'd6));
		store_word(5'd6, 32'h2345_6780);
		plain(enc_r(7'h00, 5'd5, 5'd2, 3'b101, 5'd7)); // SRL
		store_word(5'd7, 32'h0fff_ffff);
		plain(enc_r(7'h20, 5'd5, 5'd2, 3'b101, 5'd8)); // SRA
		store_word(5'd8, 32'hffff_ffff);
		plain(enc_i(OP_IMM, 3'b101, 5'd14, 5'd2, 12'h401)); // SRAI by 1
		store_word(5'd14, 32'hffff_fffd);
		plain(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));
		store_word(5'd9, 32'h0000_0001);
		plain(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd10));
		store_word(5'd10, 32'h0000_0000);
		plain(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd11));
		store_word(5'd11, 32'hedcb_a983);
		plain(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd12));
		store_word(5'd12, 32'hffff_fffb);
		plain(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd13));
		store_word(5'd13, 32'h1234_5678);

		// Loads with junk in the unused lanes
		load(3'b000, 5'd15, 32'h1234_56f0, 4'b0001);
		store_word(5'd15, 32'hffff_fff0);
		load(3'b100, 5'd16, 32'h1234_56f0, 4'b0001);
		store_word(5'd16, 32'h0000_00f0);
		load(3'b001, 5'd17, 32'habcd_8001, 4'b0011);
		store_word(5'd17, 32'hffff_8001);
		load(3'b101, 5'd18, 32'habcd_8001, 4'b0011);
		store_word(5'd18, 32'h0000_8001);
		load(3'b010, 5'd19, 32'hcafe_f00d, 4'b1111);
		store_word(5'd19, 32'hcafe_f00d);
		add_step(enc_s(3'b000, 5'd1, 5'd0, 12'h101), 32'h101, 32'h0, 32'h1234_5678,
			4'b0001, K_STORE);
		add_step(enc_s(3'b001, 5'd1, 5'd0, 12'h102), 32'h102, 32'h0, 32'h1234_5678,
			4'b0011, K_STORE);

		// x1 positive, x2 = -5, x5 = 4
		branch(3'b000, 5'd5, 5'd5, 1'b1);
		branch(3'b000, 5'd1, 5'd5, 1'b0);
		branch(3'b001, 5'd1, 5'd5, 1'b1);
		branch(3'b001, 5'd5, 5'd5, 1'b0);
		branch(3'b100, 5'd2, 5'd1, 1'b1);
		branch(3'b100, 5'd1, 5'd2, 1'b0);
		branch(3'b101, 5'd1, 5'd2, 1'b1);
		branch(3'b101, 5'd2, 5'd1, 1'b0);
		branch(3'b110, 5'd1, 5'd2, 1'b1);
		branch(3'b110, 5'd2, 5'd1, 1'b0);
		branch(3'b111, 5'd2, 5'd1, 1'b1);
		branch(3'b111, 5'd1, 5'd2, 1'b0);

		base = cur_pc;
		plain(enc_j(5'd20, 21'd12));
		cur_pc = base + 32'd12;
		store_word(5'd20, base + 32'd4); // Link value
		base = cur_pc;
		plain(enc_u(AUIPC, 5'd21, 20'h00001));
		x21_val = base + 32'h1000;
		store_word(5'd21, x21_val);
		base = cur_pc;
		plain(enc_i(JALR, 3'b000, 5'd22, 5'd21, 12'h041));
		cur_pc = (x21_val + 32'h41) & ~32'h1; // Odd target, bit 0 dropped
		store_word(5'd22, base + 32'd4);
		end_pc = cur_pc;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset      = 1'b1;
		insn_valid = 1'b0;
		mem_ready  = 1'b0;
		for (int c = 0; c < 4; c++) begin
			@(posedge clk);
		end
		@(negedge clk);
		reset = 1'b0;
		#1;
		check("insn_addr", insn_addr, RESET_PC);
		check("mem_valid", 32'(mem_valid), 32'h0);
		check("mem_wstrb", 32'(mem_wstrb), 32'h0);
		check("trap", 32'(trap), 32'h0);
	endtask

	task automatic run_program(input logic stalls);
		int stall;
		for (int i = 0; i < tbl_insn.size(); i++) begin
			stall = 0;
			if (stalls && tbl_kind[i] != K_NONE) begin
				stall = $random(seed) & 3;
			end
			@(negedge clk);
			insn       = tbl_insn[i];
			insn_valid = 1'b1;
			mem_rdata  = tbl_rdata[i];
			mem_ready  = (stall == 0);
			#1;
			check("insn_addr", insn_addr, tbl_pc[i]);
			check("trap", 32'(trap), 32'h0);
			check("mem_valid", 32'(mem_valid), 32'(tbl_kind[i] != K_NONE));
			check("mem_wstrb", 32'(mem_wstrb),
				(tbl_kind[i] == K_STORE) ? 32'(tbl_mask[i]) : 32'h0);
			check("mem_rmask", 32'(mem_rmask),
				(tbl_kind[i] == K_LOAD) ? 32'(tbl_mask[i]) : 32'h0);
			if (tbl_kind[i] != K_NONE) begin
				check("mem_addr", mem_addr, tbl_addr[i]);
			end
			if (tbl_kind[i] == K_STORE) begin
				check("mem_wdata", mem_wdata, tbl_wdata[i]);
			end
			for (int s = 1; s <= stall; s++) begin
				@(negedge clk);
				mem_ready = (s == stall); // Ready on the last stall cycle
				#1;
				check("insn_addr", insn_addr, tbl_pc[i]);
				check("mem_valid", 32'(mem_valid), 32'h1);
				check("mem_addr", mem_addr, tbl_addr[i]);
				if (tbl_kind[i] == K_STORE) begin
					check("mem_wdata", mem_wdata, tbl_wdata[i]);
				end
			end
		end
		@(negedge clk);
		insn_valid = 1'b0;
		mem_ready  = 1'b0;
		#1;
		check("insn_addr", insn_addr, end_pc);
	endtask

	task automatic check_trap(input logic [31:0] word);
		logic [31:0] frozen;
		int          n;
		@(negedge clk);
		frozen     = insn_addr;
		insn       = word;
		insn_valid = 1'b1;
		mem_ready  = 1'b1; // A leaked access would complete and move the PC
		#1;
		n = 0;
		while (!trap && n < 8) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!trap) begin
			$display("Timeout: trap was not raised for instruction %h", word);
			errors++;
		end
		for (n = 0; n < 5; n++) begin
			@(negedge clk);
			#1;
			check("insn_addr", insn_addr, frozen);
			check("trap", 32'(trap), 32'h1);
			check("mem_valid", 32'(mem_valid), 32'h0);
		end
	endtask

	initial begin
		seed       = 32'h5942;
		errors     = 0;
		reset      = 1'b1;
		insn       = 32'h0000_0013;
		insn_valid = 1'b0;
		mem_rdata  = 32'h0;
		mem_ready  = 1'b0;
		build_program();
		apply_reset();
		run_program(1'b0);
		apply_reset();
		run_program(1'b1); // Same program under back-pressure
		check_trap(32'h0000_0000);
		check_trap(enc_i(LOAD, 3'b011, 5'd1, 5'd0, 12'h000));
		$display("Error count: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
src/rv32_pkg.sv
src/insn_decoder.sv
src/alu.sv
src/next_pc.sv
src/load_store_unit.sv
src/register_file.sv
src/rv32_hart.sv
bench/rv32_hart_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv32_hart_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
